/* design/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_t op,
	input  logic [cpu_pkg::DATA_W-1:0] a,
	input  logic [cpu_pkg::DATA_W-1:0] b,
	output logic [cpu_pkg::DATA_W-1:0] y,
	output logic [cpu_pkg::FLAG_W-1:0] flags
);
	import cpu_pkg::*;

	logic [7:0] b8;
	logic cin8;
	logic [4:0] lo_sum;
	logic [8:0] sum8;
	logic ovf8;
	logic [15:0] b16;
	logic cin16;
	logic [16:0] sum16;
	logic ovf16;
	logic wide;

	// subtract as a + ~b + 1, so carry out means no borrow
	always_comb
	begin
		case (op)
		ALU_SUB:
		begin
			b8 = ~b[7:0];
			cin8 = 1'b1;
		end
		ALU_INC:
		begin
			b8 = 8'h01;
			cin8 = 1'b0;
		end
		ALU_DEC:
		begin
			b8 = 8'hfe;
			cin8 = 1'b1;
		end
		default:
		begin
			b8 = b[7:0];
			cin8 = 1'b0;
		end
		endcase
	end

	assign lo_sum = {1'b0, a[3:0]} + {1'b0, b8[3:0]} + {4'd0, cin8};
	assign sum8 = {1'b0, a[7:0]} + {1'b0, b8} + {8'd0, cin8};
	assign ovf8 = (a[7] == b8[7]) && (sum8[7] != a[7]);

	assign b16 = (op == ALU_SUBW) ? ~b : (op == ALU_INCW) ? 16'h0001 : b;
	assign cin16 = (op == ALU_SUBW);
	assign sum16 = {1'b0, a} + {1'b0, b16} + {16'd0, cin16};
	assign ovf16 = (a[15] == b16[15]) && (sum16[15] != a[15]);

	assign wide = is_word_op(op);

	always_comb
	begin
		y = '0;
		flags = '0;
		case (op)
		ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC:
		begin
			y[7:0] = sum8[7:0];
			flags[FLAG_H] = lo_sum[4];
			flags[FLAG_C] = sum8[8];
			flags[FLAG_O] = ovf8;
		end
		ALU_AND:
			y[7:0] = a[7:0] & b[7:0];
		ALU_OR:
			y[7:0] = a[7:0] | b[7:0];
		ALU_XOR:
			y[7:0] = a[7:0] ^ b[7:0];
		ALU_SRL:
		begin
			y[7:0] = {1'b0, a[7:1]};
			flags[FLAG_C] = a[0];
		end
		ALU_SLL:
		begin
			y[7:0] = {a[6:0], 1'b0};
			flags[FLAG_C] = a[7];
		end
		ALU_ADDW, ALU_SUBW, ALU_INCW:
		begin
			y = sum16[15:0];
			flags[FLAG_C] = sum16[16];
			flags[FLAG_O] = ovf16;
		end
		ALU_PASSW:
			y = a;
		default:
			y[7:0] = a[7:0];
		endcase
		// high byte is zero for byte results
		flags[FLAG_N] = wide ? y[15] : y[7];
		flags[FLAG_Z] = (y == '0);
	end

endmodule

`default_nettype wire

/* design/cpu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
	input  logic clk,
	input  logic reset,
	output logic [cpu_pkg::DATA_W-1:0] iread_addr,
	input  logic [cpu_pkg::INST_W-1:0] iread_data,
	output logic [cpu_pkg::DATA_W-1:0] dread_addr,
	input  logic [cpu_pkg::DATA_W-1:0] dread_data,
	output logic [cpu_pkg::DATA_W-1:0] dwrite_addr,
	output logic [cpu_pkg::DATA_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import cpu_pkg::*;

	logic [INST_W-1:0] inst;
	logic [FLAG_W-1:0] next_flags;
	logic [DATA_W-1:0] x;
	logic [DATA_W-1:0] y;
	logic [DATA_W-1:0] z;
	logic [DATA_W-1:0] next_z;
	logic [DATA_W-1:0] result;
	logic [DATA_W-1:0] wdata;

	addr_mode_t next_addr_mode;

	alu_op_t cur_alu_op;
	operand_sel_t cur_op_a_sel;
	operand_sel_t cur_op_b_sel;
	addr_mode_t cur_addr_mode;
	branch_t cur_branch;
	logic [1:0] cur_inst_len;
	logic [1:0] cur_reg_dest;
	logic [1:0] cur_reg_we;
	logic [1:0] cur_mem_we;
	logic [FLAG_W-1:0] cur_flag_mask;
	logic [1:0] cur_sp_delta_sel;
	logic cur_is_trap;

	fetch_unit fetch_unit (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.inst_len(cur_inst_len),
		.branch(cur_branch),
		.next_flags(next_flags),
		.iread_addr(iread_addr),
		.inst(inst)
	);

	// only the address form of the fetched instruction is needed
	decoder dec_next (
		.opcode(opcode_t'(iread_data[7:0])),
		.alu_op(),
		.op_a_sel(),
		.op_b_sel(),
		.addr_mode(next_addr_mode),
		.branch(),
		.inst_len(),
		.reg_dest(),
		.reg_we(),
		.mem_we(),
		.flag_mask(),
		.sp_delta_sel(),
		.is_trap()
	);

	decoder dec_cur (
		.opcode(opcode_t'(inst[7:0])),
		.alu_op(cur_alu_op),
		.op_a_sel(cur_op_a_sel),
		.op_b_sel(cur_op_b_sel),
		.addr_mode(cur_addr_mode),
		.branch(cur_branch),
		.inst_len(cur_inst_len),
		.reg_dest(cur_reg_dest),
		.reg_we(cur_reg_we),
		.mem_we(cur_mem_we),
		.flag_mask(cur_flag_mask),
		.sp_delta_sel(cur_sp_delta_sel),
		.is_trap(cur_is_trap)
	);

	regfile regfile (
		.clk(clk),
		.reset(reset),
		.dest(cur_reg_dest),
		.we(cur_reg_we),
		.wdata(wdata),
		.x(x),
		.y(y),
		.z(z),
		.next_z(next_z)
	);

	execute_unit execute_unit (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.op_a_sel(cur_op_a_sel),
		.op_b_sel(cur_op_b_sel),
		.alu_op(cur_alu_op),
		.flag_mask(cur_flag_mask),
		.result(result),
		.next_flags(next_flags),
		.wdata(wdata)
	);

	data_port data_port (
		.clk(clk),
		.reset(reset),
		.addr_mode_next(next_addr_mode),
		.addr_mode_cur(cur_addr_mode),
		.imm_next(iread_data[23:8]),
		.imm_cur(inst[23:8]),
		.mem_we(cur_mem_we),
		.sp_delta_sel(cur_sp_delta_sel),
		.next_z(next_z),
		.z(z),
		.xl(x[7:0]),
		.result(result),
		.dread_addr(dread_addr),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en)
	);

	assign trap = cur_is_trap & ~reset;

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 16;
	localparam int INST_W = 24;
	localparam int FLAG_W = 5;

	localparam logic [DATA_W-1:0] RESET_PC = 16'h4000;
	localparam logic [DATA_W-1:0] RESET_SP = 16'h0800;

	// flag bit positions
	localparam int FLAG_H = 0;
	localparam int FLAG_C = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_Z = 3;
	localparam int FLAG_O = 4;

	localparam logic [FLAG_W-1:0] FMASK_NONE = '0;
	localparam logic [FLAG_W-1:0] FMASK_ARITH = '1;
	localparam logic [FLAG_W-1:0] FMASK_LOGIC = FLAG_W'((1 << FLAG_N) | (1 << FLAG_Z));
	localparam logic [FLAG_W-1:0] FMASK_SHIFT = FLAG_W'((1 << FLAG_C) | (1 << FLAG_Z));
	localparam logic [FLAG_W-1:0] FMASK_WORD = FLAG_W'((1 << FLAG_C) | (1 << FLAG_N) |
		(1 << FLAG_Z) | (1 << FLAG_O));

	// register file indices
	localparam logic [1:0] REG_X = 2'd0;
	localparam logic [1:0] REG_Y = 2'd1;
	localparam logic [1:0] REG_Z = 2'd2;

	typedef enum logic [7:0] {
		OP_NOP        = 8'h00,
		OP_ADD_XL_IMM = 8'h01,
		OP_SUB_XL_IMM = 8'h02,
		OP_AND_XL_IMM = 8'h03,
		OP_OR_XL_IMM  = 8'h04,
		OP_XOR_XL_IMM = 8'h05,
		OP_CP_XL_IMM  = 8'h06,
		OP_ADD_XL_DIR = 8'h07,
		OP_SUB_XL_DIR = 8'h08,
		OP_INC_XL     = 8'h09,
		OP_DEC_XL     = 8'h0a,
		OP_SRL_XL     = 8'h0b,
		OP_SLL_XL     = 8'h0c,
		OP_LD_XL_IMM  = 8'h0d,
		OP_LD_XL_DIR  = 8'h0e,
		OP_LD_DIR_XL  = 8'h0f,
		OP_PUSH_XL    = 8'h10,
		OP_POP_XL     = 8'h11,
		OP_LDW_Y_IMM  = 8'h12,
		OP_ADDW_Y_IMM = 8'h13,
		OP_SUBW_Y_IMM = 8'h14,
		OP_INCW_Y     = 8'h15,
		OP_LDW_Z_Y    = 8'h16,
		OP_LDW_Y_ZREL = 8'h17,
		OP_LDW_DIR_Y  = 8'h18,
		OP_PUSHW_Y    = 8'h19,
		OP_POPW_Y     = 8'h1a,
		OP_JP_IMM     = 8'h1b,
		OP_JR         = 8'h1c,
		OP_JRZ        = 8'h1d,
		OP_JRNZ       = 8'h1e,
		OP_JRC        = 8'h1f,
		OP_JRNC       = 8'h20,
		OP_TRAP       = 8'hff
	} opcode_t;

	typedef enum logic [4:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_SRL,
		ALU_SLL,
		ALU_ADDW,
		ALU_SUBW,
		ALU_INCW,
		ALU_PASS,
		ALU_PASSW
	} alu_op_t;

	typedef enum logic [2:0] {
		SEL_XL,
		SEL_Y,
		SEL_IMM8,
		SEL_IMM16,
		SEL_RD8,
		SEL_RD16,
		SEL_ZERO
	} operand_sel_t;

	typedef enum logic [2:0] {
		AM_NONE,
		AM_DIRECT,
		AM_ZOFF,
		AM_STACK,
		AM_PUSH
	} addr_mode_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_REL,
		BR_JZ,
		BR_JNZ,
		BR_JC,
		BR_JNC,
		BR_ABS
	} branch_t;

	// 16-bit alu functions
	function automatic logic is_word_op(alu_op_t op);
		return op inside {ALU_ADDW, ALU_SUBW, ALU_INCW, ALU_PASSW};
	endfunction

endpackage

`default_nettype wire

/* design/data_port.sv */
`timescale 1ns/10ps
`default_nettype none

module data_port (
	input  logic clk,
	input  logic reset,
	input  cpu_pkg::addr_mode_t addr_mode_next,
	input  cpu_pkg::addr_mode_t addr_mode_cur,
	input  logic [cpu_pkg::DATA_W-1:0] imm_next,
	input  logic [cpu_pkg::DATA_W-1:0] imm_cur,
	input  logic [1:0] mem_we,
	input  logic [1:0] sp_delta_sel,
	input  logic [cpu_pkg::DATA_W-1:0] next_z,
	input  logic [cpu_pkg::DATA_W-1:0] z,
	input  logic [7:0] xl,
	input  logic [cpu_pkg::DATA_W-1:0] result,
	output logic [cpu_pkg::DATA_W-1:0] dread_addr,
	output logic [cpu_pkg::DATA_W-1:0] dwrite_addr,
	output logic [cpu_pkg::DATA_W-1:0] dwrite_data,
	output logic [1:0] dwrite_en
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] sp;
	logic [DATA_W-1:0] next_sp;
	logic [DATA_W-1:0] delta;
	logic [DATA_W-1:0] push_slot;

	assign delta = DATA_W'(sp_delta_sel);
	assign push_slot = sp - delta;

	always_comb
	begin
		if (reset)
			next_sp = RESET_SP;
		else if (addr_mode_cur == AM_PUSH)
			next_sp = push_slot;
		else if (addr_mode_cur == AM_STACK)
			next_sp = sp + delta;
		else
			next_sp = sp;
	end

	always_ff @(posedge clk)
		sp <= next_sp;

	// read for the fetched instruction, so use the post-execute sp and z
	always_comb
	begin
		case (addr_mode_next)
		AM_DIRECT:
			dread_addr = imm_next;
		AM_ZOFF:
			dread_addr = next_z + imm_next;
		default:
			dread_addr = next_sp;
		endcase
	end

	always_comb
	begin
		case (addr_mode_cur)
		AM_ZOFF:
			dwrite_addr = z + imm_cur;
		AM_PUSH:
			dwrite_addr = push_slot;
		AM_STACK:
			dwrite_addr = sp;
		default:
			dwrite_addr = imm_cur;
		endcase
	end

	assign dwrite_en = reset ? 2'b00 : mem_we;
	assign dwrite_data = mem_we[1] ? result : {8'h00, xl};

endmodule

`default_nettype wire

/* design/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
	input  cpu_pkg::opcode_t opcode,
	output cpu_pkg::alu_op_t alu_op,
	output cpu_pkg::operand_sel_t op_a_sel,
	output cpu_pkg::operand_sel_t op_b_sel,
	output cpu_pkg::addr_mode_t addr_mode,
	output cpu_pkg::branch_t branch,
	output logic [1:0] inst_len,
	output logic [1:0] reg_dest,
	output logic [1:0] reg_we,
	output logic [1:0] mem_we,
	output logic [cpu_pkg::FLAG_W-1:0] flag_mask,
	output logic [1:0] sp_delta_sel,
	output logic is_trap
);
	import cpu_pkg::*;

	always_comb
	begin
		op_a_sel = SEL_ZERO;
		op_b_sel = SEL_ZERO;
		addr_mode = AM_NONE;
		branch = BR_NONE;
		inst_len = 2'd1;
		reg_dest = REG_X;
		reg_we = 2'b00;
		mem_we = 2'b00;
		sp_delta_sel = 2'd0;
		is_trap = 1'b0;
		case (opcode)
		OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM,
		OP_CP_XL_IMM:
		begin
			op_a_sel = SEL_XL;
			op_b_sel = SEL_IMM8;
			inst_len = 2'd2;
			// cp only updates flags
			reg_we = (opcode == OP_CP_XL_IMM) ? 2'b00 : 2'b01;
		end
		OP_ADD_XL_DIR, OP_SUB_XL_DIR:
		begin
			op_a_sel = SEL_XL;
			op_b_sel = SEL_RD8;
			addr_mode = AM_DIRECT;
			inst_len = 2'd3;
			reg_we = 2'b01;
		end
		OP_INC_XL, OP_DEC_XL, OP_SRL_XL, OP_SLL_XL:
		begin
			op_a_sel = SEL_XL;
			reg_we = 2'b01;
		end
		OP_LD_XL_IMM:
		begin
			op_a_sel = SEL_IMM8;
			inst_len = 2'd2;
			reg_we = 2'b01;
		end
		OP_LD_XL_DIR:
		begin
			op_a_sel = SEL_RD8;
			addr_mode = AM_DIRECT;
			inst_len = 2'd3;
			reg_we = 2'b01;
		end
		OP_LD_DIR_XL:
		begin
			op_a_sel = SEL_XL;
			addr_mode = AM_DIRECT;
			inst_len = 2'd3;
			mem_we = 2'b01;
		end
		OP_PUSH_XL:
		begin
			op_a_sel = SEL_XL;
			addr_mode = AM_PUSH;
			mem_we = 2'b01;
			sp_delta_sel = 2'd1;
		end
		OP_POP_XL:
		begin
			op_a_sel = SEL_RD8;
			addr_mode = AM_STACK;
			reg_we = 2'b01;
			sp_delta_sel = 2'd1;
		end
		OP_LDW_Y_IMM:
		begin
			op_a_sel = SEL_IMM16;
			inst_len = 2'd3;
			reg_dest = REG_Y;
			reg_we = 2'b11;
		end
		OP_ADDW_Y_IMM, OP_SUBW_Y_IMM:
		begin
			op_a_sel = SEL_Y;
			op_b_sel = SEL_IMM16;
			inst_len = 2'd3;
			reg_dest = REG_Y;
			reg_we = 2'b11;
		end
		OP_INCW_Y:
		begin
			op_a_sel = SEL_Y;
			reg_dest = REG_Y;
			reg_we = 2'b11;
		end
		OP_LDW_Z_Y:
		begin
			op_a_sel = SEL_Y;
			reg_dest = REG_Z;
			reg_we = 2'b11;
		end
		OP_LDW_Y_ZREL:
		begin
			op_a_sel = SEL_RD16;
			addr_mode = AM_ZOFF;
			inst_len = 2'd3;
			reg_dest = REG_Y;
			reg_we = 2'b11;
		end
		OP_LDW_DIR_Y:
		begin
			op_a_sel = SEL_Y;
			addr_mode = AM_DIRECT;
			inst_len = 2'd3;
			mem_we = 2'b11;
		end
		OP_PUSHW_Y:
		begin
			op_a_sel = SEL_Y;
			addr_mode = AM_PUSH;
			mem_we = 2'b11;
			sp_delta_sel = 2'd2;
		end
		OP_POPW_Y:
		begin
			op_a_sel = SEL_RD16;
			addr_mode = AM_STACK;
			reg_dest = REG_Y;
			reg_we = 2'b11;
			sp_delta_sel = 2'd2;
		end
		OP_JP_IMM:
		begin
			branch = BR_ABS;
			inst_len = 2'd3;
		end
		OP_JR:
		begin
			branch = BR_REL;
			inst_len = 2'd2;
		end
		OP_JRZ:
		begin
			branch = BR_JZ;
			inst_len = 2'd2;
		end
		OP_JRNZ:
		begin
			branch = BR_JNZ;
			inst_len = 2'd2;
		end
		OP_JRC:
		begin
			branch = BR_JC;
			inst_len = 2'd2;
		end
		OP_JRNC:
		begin
			branch = BR_JNC;
			inst_len = 2'd2;
		end
		OP_TRAP:
			is_trap = 1'b1;
		default:
			is_trap = 1'b0;
		endcase
	end

	always_comb
	begin
		case (opcode)
		OP_ADD_XL_IMM, OP_ADD_XL_DIR:
			alu_op = ALU_ADD;
		// cp is a sub without write-back
		OP_SUB_XL_IMM, OP_SUB_XL_DIR, OP_CP_XL_IMM:
			alu_op = ALU_SUB;
		OP_AND_XL_IMM:
			alu_op = ALU_AND;
		OP_OR_XL_IMM:
			alu_op = ALU_OR;
		OP_XOR_XL_IMM:
			alu_op = ALU_XOR;
		OP_INC_XL:
			alu_op = ALU_INC;
		OP_DEC_XL:
			alu_op = ALU_DEC;
		OP_SRL_XL:
			alu_op = ALU_SRL;
		OP_SLL_XL:
			alu_op = ALU_SLL;
		OP_ADDW_Y_IMM:
			alu_op = ALU_ADDW;
		OP_SUBW_Y_IMM:
			alu_op = ALU_SUBW;
		OP_INCW_Y:
			alu_op = ALU_INCW;
		OP_LDW_Y_IMM, OP_LDW_Z_Y, OP_LDW_Y_ZREL, OP_LDW_DIR_Y, OP_PUSHW_Y, OP_POPW_Y:
			alu_op = ALU_PASSW;
		default:
			alu_op = ALU_PASS;
		endcase
	end

	// flags touched follow the alu function
	always_comb
	begin
		case (alu_op)
		ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC:
			flag_mask = FMASK_ARITH;
		ALU_AND, ALU_OR, ALU_XOR:
			flag_mask = FMASK_LOGIC;
		ALU_SRL, ALU_SLL:
			flag_mask = FMASK_SHIFT;
		ALU_ADDW, ALU_SUBW, ALU_INCW:
			flag_mask = FMASK_WORD;
		default:
			flag_mask = FMASK_NONE;
		endcase
	end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_unit (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_pkg::INST_W-1:0] inst,
	input  logic [cpu_pkg::DATA_W-1:0] x,
	input  logic [cpu_pkg::DATA_W-1:0] y,
	input  logic [cpu_pkg::DATA_W-1:0] dread_data,
	input  cpu_pkg::operand_sel_t op_a_sel,
	input  cpu_pkg::operand_sel_t op_b_sel,
	input  cpu_pkg::alu_op_t alu_op,
	input  logic [cpu_pkg::FLAG_W-1:0] flag_mask,
	output logic [cpu_pkg::DATA_W-1:0] result,
	output logic [cpu_pkg::FLAG_W-1:0] next_flags,
	output logic [cpu_pkg::DATA_W-1:0] wdata
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [FLAG_W-1:0] alu_flags;
	logic [FLAG_W-1:0] flags;

	function automatic logic [DATA_W-1:0] pick(operand_sel_t sel);
		case (sel)
		SEL_XL:
			return {8'h00, x[7:0]};
		SEL_Y:
			return y;
		SEL_IMM8:
			return {8'h00, inst[15:8]};
		SEL_IMM16:
			return inst[23:8];
		SEL_RD8:
			return {8'h00, dread_data[7:0]};
		SEL_RD16:
			return dread_data;
		default:
			return '0;
		endcase
	endfunction

	always_comb
	begin
		op_a = pick(op_a_sel);
		op_b = pick(op_b_sel);
	end

	alu alu (
		.op(alu_op),
		.a(op_a),
		.b(op_b),
		.y(result),
		.flags(alu_flags)
	);

	// byte results land in xl, xh keeps its value
	assign wdata = is_word_op(alu_op) ? result : {x[15:8], result[7:0]};

	// only the flags this op defines are updated
	assign next_flags = (alu_flags & flag_mask) | (flags & ~flag_mask);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
	input  logic clk,
	input  logic reset,
	input  logic [cpu_pkg::INST_W-1:0] iread_data,
	input  logic [1:0] inst_len,
	input  cpu_pkg::branch_t branch,
	input  logic [cpu_pkg::FLAG_W-1:0] next_flags,
	output logic [cpu_pkg::DATA_W-1:0] iread_addr,
	output logic [cpu_pkg::INST_W-1:0] inst
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] pc;
	logic [DATA_W-1:0] seq_pc;
	logic [DATA_W-1:0] rel_pc;
	logic taken;

	assign seq_pc = pc + DATA_W'(inst_len);
	// offset counts from the byte after the branch
	assign rel_pc = seq_pc + {{8{inst[15]}}, inst[15:8]};

	always_comb
	begin
		case (branch)
		BR_REL:
			taken = 1'b1;
		BR_JZ:
			taken = next_flags[FLAG_Z];
		BR_JNZ:
			taken = !next_flags[FLAG_Z];
		BR_JC:
			taken = next_flags[FLAG_C];
		BR_JNC:
			taken = !next_flags[FLAG_C];
		default:
			taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			iread_addr = RESET_PC;
		else if (branch == BR_ABS)
			iread_addr = inst[23:8];
		else if (taken)
			iread_addr = rel_pc;
		else
			iread_addr = seq_pc;
	end

	always_ff @(posedge clk)
	begin
		pc <= iread_addr;
		inst <= iread_data;
	end

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
	input  logic clk,
	input  logic reset,
	input  logic [1:0] dest,
	input  logic [1:0] we,
	input  logic [cpu_pkg::DATA_W-1:0] wdata,
	output logic [cpu_pkg::DATA_W-1:0] x,
	output logic [cpu_pkg::DATA_W-1:0] y,
	output logic [cpu_pkg::DATA_W-1:0] z,
	output logic [cpu_pkg::DATA_W-1:0] next_z
);
	import cpu_pkg::*;

	logic [DATA_W-1:0] regs [3];
	logic [1:0] we_eff;

	assign we_eff = reset ? 2'b00 : we;

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];

	// z as it will be after this cycle, for z-relative reads
	assign next_z = {
		(dest == REG_Z && we_eff[1]) ? wdata[15:8] : regs[REG_Z][15:8],
		(dest == REG_Z && we_eff[0]) ? wdata[7:0] : regs[REG_Z][7:0]
	};

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (we_eff[0] && dest == i)
				regs[i][7:0] <= wdata[7:0];
			if (we_eff[1] && dest == i)
				regs[i][15:8] <= wdata[15:8];
		end
	end

endmodule

`default_nettype wire

/* list.f */
design/cpu_pkg.sv
design/decoder.sv
design/alu.sv
design/regfile.sv
design/execute_unit.sv
design/fetch_unit.sv
design/data_port.sv
design/cpu_core.sv
testbench/tb_cpu.sv

/* run.sh */
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module tb_cpu -f list.f -o tb_cpu &&
	./obj_dir/tb_cpu | tee /dev/stderr | grep -q "RESULT: PASS" &&
	echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }

/* testbench/tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] prog [65536];
	logic [7:0] data_mem [65536];
	logic [7:0] model_mem [65536];

	logic [15:0] lfsr;
	logic [15:0] gen_addr;

	// instruction-level model state
	logic [15:0] model_pc;
	logic [15:0] model_sp;
	logic [7:0] model_x;
	logic [15:0] model_y;
	logic [15:0] model_z;
	logic model_z_flag;
	logic model_c;
	logic [1:0] exp_we;
	logic [15:0] exp_waddr;
	logic [15:0] exp_wdata;
	logic done;
	int cycles;

	cpu_core uut (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	always #4 clk = ~clk;

	// instruction port answers in the same cycle
	assign iread_data = {prog[iread_addr + 16'd2], prog[iread_addr + 16'd1], prog[iread_addr]};

	// data port: writes land first, so a read of the same byte sees the new value
	always @(posedge clk)
	begin
		if (dwrite_en[0])
			data_mem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			data_mem[dwrite_addr + 16'd1] = dwrite_data[15:8];
		dread_data <= {data_mem[dread_addr + 16'd1], data_mem[dread_addr]};
	end

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [15:0] random_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] fill_byte(logic [15:0] a);
		return a[7:0] ^ {a[12:8], a[15:13]} ^ 8'ha5;
	endfunction

	function automatic int instruction_length(opcode_t op);
		case (op)
		OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM,
		OP_CP_XL_IMM, OP_LD_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
			return 2;
		OP_ADD_XL_DIR, OP_SUB_XL_DIR, OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMM,
		OP_ADDW_Y_IMM, OP_SUBW_Y_IMM, OP_LDW_Y_ZREL, OP_LDW_DIR_Y, OP_JP_IMM:
			return 3;
		default:
			return 1;
		endcase
	endfunction

	function automatic opcode_t one_byte_op();
		opcode_t op;
		do
			op = opcode_t'(8'(random_bits(6) % 16'd33));
		while (instruction_length(op) != 1);
		return op;
	endfunction

	task automatic emit_byte(input logic [7:0] b);
		prog[gen_addr] = b;
		gen_addr = gen_addr + 16'd1;
	endtask

	task automatic generate_program();
		opcode_t op;
		logic [7:0] skip;
		logic [15:0] target;
		gen_addr = RESET_PC;
		emit_byte(OP_LD_XL_IMM);
		emit_byte(8'(random_bits(8)));
		emit_byte(OP_LDW_Y_IMM);
		emit_byte(8'(random_bits(8)));
		emit_byte(8'(random_bits(8)));
		emit_byte(OP_LDW_Z_Y);
		emit_byte(OP_LDW_Y_IMM);
		emit_byte(8'(random_bits(8)));
		emit_byte(8'(random_bits(8)));
		for (int i = 4; i < 40; i++)
		begin
			op = opcode_t'(8'(random_bits(6) % 16'd33));
			skip = 8'(random_bits(2));
			emit_byte(op);
			case (op)
			OP_ADD_XL_DIR, OP_SUB_XL_DIR, OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_DIR_Y:
			begin
				// direct operands stay in page 0x01
				emit_byte(8'(random_bits(8)));
				emit_byte(8'h01);
			end
			OP_JP_IMM:
			begin
				target = gen_addr + 16'd2 + 16'(skip);
				emit_byte(target[7:0]);
				emit_byte(target[15:8]);
			end
			OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				emit_byte(skip);
			default:
				for (int k = 1; k < instruction_length(op); k++)
					emit_byte(8'(random_bits(8)));
			endcase
			// skipped bytes are whole one-byte instructions, so both paths stay valid
			if (op inside {OP_JP_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC})
				for (int k = 0; k < int'(skip); k++)
					emit_byte(one_byte_op());
		end
		emit_byte(OP_TRAP);
	endtask

	task automatic add_sub_byte(input logic [7:0] a, input logic [7:0] b, input logic sub,
		output logic [7:0] r);
		if (sub)
		begin
			r = a - b;
			model_c = (a >= b);
		end
		else
			{model_c, r} = {1'b0, a} + {1'b0, b};
		model_z_flag = (r == 8'h00);
	endtask

	task automatic add_sub_word(input logic [15:0] a, input logic [15:0] b, input logic sub,
		output logic [15:0] r);
		if (sub)
		begin
			r = a - b;
			model_c = (a >= b);
		end
		else
			{model_c, r} = {1'b0, a} + {1'b0, b};
		model_z_flag = (r == 16'h0000);
	endtask

	task automatic write_xl_logic(input logic [7:0] r);
		model_x = r;
		model_z_flag = (r == 8'h00);
	endtask

	function automatic logic [15:0] read_word(logic [15:0] a);
		return {model_mem[a + 16'd1], model_mem[a]};
	endfunction

	task automatic store_bytes(input logic [15:0] a, input logic [15:0] d, input logic [1:0] we);
		exp_we = we;
		exp_waddr = a;
		exp_wdata = d;
		model_mem[a] = d[7:0];
		if (we[1])
			model_mem[a + 16'd1] = d[15:8];
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// read address for the instruction being fetched, from the model state after this cycle
	task automatic check_read_address();
		opcode_t op;
		logic [15:0] imm;
		op = opcode_t'(prog[model_pc]);
		imm = {prog[model_pc + 16'd2], prog[model_pc + 16'd1]};
		case (op)
		OP_ADD_XL_DIR, OP_SUB_XL_DIR, OP_LD_XL_DIR:
			check_value("dread_addr", dread_addr, imm);
		OP_LDW_Y_ZREL:
			check_value("dread_addr", dread_addr, model_z + imm);
		OP_POP_XL, OP_POPW_Y:
			check_value("dread_addr", dread_addr, model_sp);
		default:
			;
		endcase
	endtask

	task automatic execute_and_compare();
		opcode_t op;
		logic [7:0] i1;
		logic [7:0] scratch;
		logic [15:0] imm;
		logic [15:0] rel;
		logic [15:0] next_pc;
		op = opcode_t'(prog[model_pc]);
		i1 = prog[model_pc + 16'd1];
		imm = {prog[model_pc + 16'd2], i1};
		rel = model_pc + 16'd2 + {{8{i1[7]}}, i1};
		next_pc = model_pc + 16'(instruction_length(op));
		exp_we = 2'b00;
		case (op)
		OP_ADD_XL_IMM: add_sub_byte(model_x, i1, 1'b0, model_x);
		OP_SUB_XL_IMM: add_sub_byte(model_x, i1, 1'b1, model_x);
		OP_AND_XL_IMM: write_xl_logic(model_x & i1);
		OP_OR_XL_IMM: write_xl_logic(model_x | i1);
		OP_XOR_XL_IMM: write_xl_logic(model_x ^ i1);
		OP_CP_XL_IMM: add_sub_byte(model_x, i1, 1'b1, scratch);
		OP_ADD_XL_DIR: add_sub_byte(model_x, model_mem[imm], 1'b0, model_x);
		OP_SUB_XL_DIR: add_sub_byte(model_x, model_mem[imm], 1'b1, model_x);
		OP_INC_XL: add_sub_byte(model_x, 8'h01, 1'b0, model_x);
		OP_DEC_XL: add_sub_byte(model_x, 8'h01, 1'b1, model_x);
		OP_SRL_XL:
		begin
			model_c = model_x[0];
			model_x = model_x >> 1;
			model_z_flag = (model_x == 8'h00);
		end
		OP_SLL_XL:
		begin
			model_c = model_x[7];
			model_x = model_x << 1;
			model_z_flag = (model_x == 8'h00);
		end
		OP_LD_XL_IMM: model_x = i1;
		OP_LD_XL_DIR: model_x = model_mem[imm];
		OP_LD_DIR_XL: store_bytes(imm, {8'h00, model_x}, 2'b01);
		OP_PUSH_XL:
		begin
			model_sp = model_sp - 16'd1;
			store_bytes(model_sp, {8'h00, model_x}, 2'b01);
		end
		OP_POP_XL:
		begin
			model_x = model_mem[model_sp];
			model_sp = model_sp + 16'd1;
		end
		OP_LDW_Y_IMM: model_y = imm;
		OP_ADDW_Y_IMM: add_sub_word(model_y, imm, 1'b0, model_y);
		OP_SUBW_Y_IMM: add_sub_word(model_y, imm, 1'b1, model_y);
		OP_INCW_Y: add_sub_word(model_y, 16'h0001, 1'b0, model_y);
		OP_LDW_Z_Y: model_z = model_y;
		OP_LDW_Y_ZREL: model_y = read_word(model_z + imm);
		OP_LDW_DIR_Y: store_bytes(imm, model_y, 2'b11);
		OP_PUSHW_Y:
		begin
			model_sp = model_sp - 16'd2;
			store_bytes(model_sp, model_y, 2'b11);
		end
		OP_POPW_Y:
		begin
			model_y = read_word(model_sp);
			model_sp = model_sp + 16'd2;
		end
		OP_JP_IMM: next_pc = imm;
		OP_JR: next_pc = rel;
		OP_JRZ: next_pc = model_z_flag ? rel : next_pc;
		OP_JRNZ: next_pc = !model_z_flag ? rel : next_pc;
		OP_JRC: next_pc = model_c ? rel : next_pc;
		OP_JRNC: next_pc = !model_c ? rel : next_pc;
		default: next_pc = next_pc;
		endcase
		check_value("iread_addr", iread_addr, next_pc);
		check_value("dwrite_en", 16'(dwrite_en), 16'(exp_we));
		if (exp_we != 2'b00)
		begin
			check_value("dwrite_addr", dwrite_addr, exp_waddr);
			check_value("dwrite_data[7:0]", 16'(dwrite_data[7:0]), 16'(exp_wdata[7:0]));
			if (exp_we[1])
				check_value("dwrite_data[15:8]", 16'(dwrite_data[15:8]), 16'(exp_wdata[15:8]));
		end
		check_value("trap", 16'(trap), 16'(op == OP_TRAP));
		done = (op == OP_TRAP);
		model_pc = next_pc;
		check_read_address();
	endtask

	initial
	begin
		reset <= 1'b1;
		dread_data <= 16'h0000;
		lfsr = 16'd76;
		for (int a = 0; a < 65536; a++)
		begin
			prog[a] = 8'h00;
			data_mem[a] = fill_byte(16'(a));
			model_mem[a] = fill_byte(16'(a));
		end
		generate_program();
		// word push at the start address for the first reset cycle
		prog[RESET_PC] = OP_PUSHW_Y;
		model_pc = RESET_PC;
		model_sp = RESET_SP;
		model_x = 8'h00;
		model_y = 16'h0000;
		model_z = 16'h0000;
		model_z_flag = 1'b0;
		model_c = 1'b0;
		done = 1'b0;

		@(posedge clk);
		@(negedge clk);
		check_value("dwrite_en", 16'(dwrite_en), 16'h0000);
		check_value("iread_addr", iread_addr, RESET_PC);
		prog[RESET_PC] = OP_LD_XL_IMM;
		@(posedge clk);
		reset <= 1'b0;

		// one instruction per cycle until the trap
		cycles = 0;
		while (!done && cycles < 200)
		begin
			@(negedge clk);
			execute_and_compare();
			cycles++;
		end

		if (done)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
		begin
			$display("trap was not reached within 200 cycles");
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

endmodule

`default_nettype wire
